// File: all.f
hdl/icache_pkg.sv
hdl/icache_tag_store.sv
hdl/icache_data_store.sv
hdl/icache_lookup.sv
hdl/icache_refill.sv
hdl/icache_top.sv
testbench/icache_tb_mem.sv
testbench/icache_tb.sv

// File: testbench/icache_tb.sv
//////////////////////////////////////////////////
// Instruction cache testbench
// Directed tests for hits, refills, streaming,
// LRU replacement, fence and reset behavior
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module icache_tb;

  localparam int test_count = 6;
  localparam int cycle_ns   = 40;

  logic                              clk_i;
  logic                              reset_i;
  logic                              fetch_v_i;
  icache_pkg::icache_op_e            fetch_op_i;
  logic [icache_pkg::addr_width-1:0] fetch_addr_i;
  logic                              ready_o;
  logic [icache_pkg::word_width-1:0] data_o;
  logic                              data_v_o;
  logic                              miss_v_o;
  icache_pkg::wb_m2s_s               wb;
  logic [icache_pkg::word_width-1:0] wb_dat;
  logic                              wb_ack;
  int                                errors;
  int                                checks;

  icache_top #(.sets_p(16), .block_words_p(4)) dut_i (
    .clk_i, .reset_i, .fetch_v_i, .fetch_op_i, .fetch_addr_i,
    .ready_o, .data_o, .data_v_o, .miss_v_o,
    .wb_o(wb), .wb_dat_i(wb_dat), .wb_ack_i(wb_ack)
  );

  icache_tb_mem mem_i (.clk_i, .reset_i, .wb_i(wb), .wb_dat_o(wb_dat), .wb_ack_o(wb_ack));

  always #(cycle_ns / 2) clk_i = ~clk_i;

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [31:0] wa;
    wa = {2'b00, addr[31:2]};
    return {wa[31:16], ~wa[15:0]};
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic wait_ready;
    @(negedge clk_i);
    while (!ready_o)
      @(negedge clk_i);
  endtask

  // Result is sampled in the cycle after the second edge past acceptance
  task automatic issue_request(input icache_pkg::icache_op_e op, input logic [31:0] addr,
                               output logic hit, output logic miss, output logic [31:0] data);
    @(posedge clk_i);
    fetch_v_i    <= 1'b1;
    fetch_op_i   <= op;
    fetch_addr_i <= addr;
    wait_ready();
    @(posedge clk_i);
    fetch_v_i <= 1'b0;
    @(negedge clk_i);
    compare("data_v_o", data_v_o, 0);
    compare("miss_v_o", miss_v_o, 0);
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    hit  = data_v_o;
    miss = miss_v_o;
    data = data_o;
  endtask

  task automatic fetch_hit(input logic [31:0] addr);
    logic        hit;
    logic        miss;
    logic [31:0] data;
    issue_request(icache_pkg::e_op_fetch, addr, hit, miss, data);
    compare("data_v_o", hit, 1);
    compare("data_o", data, expected_word(addr));
  endtask

  task automatic miss_then_fill(input logic [31:0] addr);
    logic        hit;
    logic        miss;
    logic [31:0] data;
    issue_request(icache_pkg::e_op_fetch, addr, hit, miss, data);
    compare("miss_v_o", miss, 1);
    compare("data_v_o", hit, 0);
    fetch_hit(addr);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic reset_state;
    reset_i <= 1'b1;
    repeat (8)
    begin
      @(negedge clk_i);
      compare("ready_o", ready_o, 0);
      compare("data_v_o", data_v_o, 0);
      compare("miss_v_o", miss_v_o, 0);
      compare("wb_o.cyc", wb.cyc, 0);
      compare("wb_o.stb", wb.stb, 0);
    end
    @(posedge clk_i);
    reset_i <= 1'b0;
    // First edge where the DUT sees reset low
    @(posedge clk_i);
    @(negedge clk_i);
    compare("ready_o", ready_o, 1);
    compare("data_v_o", data_v_o, 0);
    compare("miss_v_o", miss_v_o, 0);
    compare("wb_o.cyc", wb.cyc, 0);
    compare("wb_o.stb", wb.stb, 0);
  endtask

  task automatic cold_miss_then_hit;
    miss_then_fill(32'h0000_1040);
  endtask

  task automatic line_fill;
    fetch_hit(32'h0000_1044);
    fetch_hit(32'h0000_1048);
    fetch_hit(32'h0000_104c);
  endtask

  task automatic streaming_hits;
    logic [31:0] addrs [6];
    addrs = '{32'h0000_1048, 32'h0000_2084, 32'h0000_1040,
              32'h0000_208c, 32'h0000_2080, 32'h0000_104c};
    miss_then_fill(32'h0000_2088);
    wait_ready();
    for (int j = 0; j < 9; j++)
    begin
      @(posedge clk_i);
      if (j < 6)
      begin
        fetch_v_i    <= 1'b1;
        fetch_op_i   <= icache_pkg::e_op_fetch;
        fetch_addr_i <= addrs[j];
      end
      else
        fetch_v_i <= 1'b0;
      @(negedge clk_i);
      if (j < 6)
        compare("ready_o", ready_o, 1);
      if (j >= 3)
      begin
        compare("data_v_o", data_v_o, 1);
        compare("data_o", data_o, expected_word(addrs[j-3]));
      end
      else
        compare("data_v_o", data_v_o, 0);
    end
  endtask

  // Tags A, B and C all map to set 5
  task automatic lru_replacement;
    miss_then_fill(32'h0000_0150);
    miss_then_fill(32'h0000_0254);
    fetch_hit(32'h0000_0158);
    miss_then_fill(32'h0000_035c);
    fetch_hit(32'h0000_015c);
    miss_then_fill(32'h0000_0250);
  endtask

  task automatic fence_flush;
    logic        hit;
    logic        miss;
    logic [31:0] data;
    issue_request(icache_pkg::e_op_fence, 32'h0, hit, miss, data);
    compare("data_v_o", hit, 0);
    compare("miss_v_o", miss, 0);
    compare("ready_o", ready_o, 0);
    @(negedge clk_i);
    compare("ready_o", ready_o, 1);
    miss_then_fill(32'h0000_1044);
  endtask

  initial
  begin
    clk_i        = 1'b0;
    reset_i      = 1'b1;
    fetch_v_i    = 1'b0;
    fetch_op_i   = icache_pkg::e_op_fetch;
    fetch_addr_i = '0;
    errors       = 0;
    checks       = 0;
    reset_state();
    cold_miss_then_hit();
    line_fill();
    streaming_hits();
    lru_replacement();
    fence_flush();
    repeat (2) @(posedge clk_i);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(test_count * 400 * cycle_ns);
    $display("Run did not finish within %0d cycles, stopping", test_count * 400);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/icache_tb_mem.sv
//////////////////////////////////////////////////
// Wishbone classic memory model
// Acks each strobe after 1 to 4 random cycles and
// returns a word derived from the word address
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module icache_tb_mem (
  input  wire                               clk_i,
  input  wire                               reset_i,
  input  wire icache_pkg::wb_m2s_s          wb_i,
  output logic [icache_pkg::word_width-1:0] wb_dat_o,
  output logic                              wb_ack_o
);

  // Upper half of the word address, then its lower half inverted
  function automatic logic [31:0] word_at(input logic [31:0] adr);
    logic [31:0] wa;
    wa = {2'b00, adr[31:2]};
    return {wa[31:16], ~wa[15:0]};
  endfunction

  initial
  begin : responder
    int delay;
    wb_ack_o = 1'b0;
    wb_dat_o = '0;
    void'($urandom(32'hebba));
    forever
    begin
      @(posedge clk_i);
      wb_ack_o <= 1'b0;
      // New strobe seen, the previous ack is already gone
      if (!reset_i && wb_i.cyc && wb_i.stb && !wb_ack_o)
      begin
        delay = ($urandom % 4) + 1;
        repeat (delay - 1) @(posedge clk_i);
        wb_ack_o <= 1'b1;
        wb_dat_o <= word_at(wb_i.adr);
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/icache_top.sv
//////////////////////////////////////////////////
// Two-way set-associative instruction cache
// Three stage lookup pipeline over tag and data
// stores, with a Wishbone classic line refill
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module icache_top #(
  parameter int sets_p        = 16,
  parameter int block_words_p = 4,
  localparam int offset_w = $clog2(block_words_p),
  localparam int index_w  = $clog2(sets_p),
  localparam int tag_w    = icache_pkg::addr_width - 2 - offset_w - index_w
) (
  input  wire                                  clk_i,
  input  wire                                  reset_i,
  // Fetch side
  input  wire                                  fetch_v_i,
  input  wire icache_pkg::icache_op_e          fetch_op_i,
  input  wire [icache_pkg::addr_width-1:0]     fetch_addr_i,
  output logic                                 ready_o,
  output logic [icache_pkg::word_width-1:0]    data_o,
  output logic                                 data_v_o,
  output logic                                 miss_v_o,
  // Memory side
  output icache_pkg::wb_m2s_s                  wb_o,
  input  wire [icache_pkg::word_width-1:0]     wb_dat_i,
  input  wire                                  wb_ack_i
);

  localparam int ways = icache_pkg::ways;

  // Read port, driven in decode
  logic                                                rd_en;
  logic [index_w-1:0]                                  rd_index;
  logic [ways-1:0][tag_w-1:0]                          tag_rd;
  logic [ways-1:0]                                     valid_rd;
  logic                                                lru_rd;
  logic [ways-1:0][block_words_p-1:0][icache_pkg::word_width-1:0] line_rd;

  // Lookup to refill and stores
  logic                                refill_v;
  logic [icache_pkg::addr_width-1:0]   refill_addr;
  logic                                victim_way;
  logic                                lru_we;
  logic [index_w-1:0]                  lru_index;
  logic                                lru_way;
  logic                                clear_all;

  // Refill write ports
  logic                                refill_busy;
  logic                                wr_en;
  logic                                wr_way;
  logic [index_w-1:0]                  wr_index;
  logic [offset_w-1:0]                 wr_word;
  logic [icache_pkg::word_width-1:0]   wr_data;
  logic                                tag_we;
  logic [tag_w-1:0]                    tag_wr;

  icache_lookup #(
    .sets_p        (sets_p),
    .block_words_p (block_words_p)
  ) lookup_i (
    .clk_i, .reset_i, .fetch_v_i, .fetch_op_i, .fetch_addr_i, .ready_o,
    .rd_en_o       (rd_en),
    .rd_index_o    (rd_index),
    .tag_i         (tag_rd),
    .valid_i       (valid_rd),
    .lru_i         (lru_rd),
    .line_i        (line_rd),
    .data_o, .data_v_o, .miss_v_o,
    .refill_v_o    (refill_v),
    .refill_addr_o (refill_addr),
    .victim_way_o  (victim_way),
    .refill_busy_i (refill_busy),
    .lru_we_o      (lru_we),
    .lru_index_o   (lru_index),
    .lru_way_o     (lru_way),
    .clear_all_o   (clear_all)
  );

  icache_tag_store #(
    .sets_p        (sets_p),
    .block_words_p (block_words_p)
  ) tag_store_i (
    .clk_i, .reset_i,
    .rd_en_i       (rd_en),
    .rd_index_i    (rd_index),
    .wr_en_i       (tag_we),
    .wr_way_i      (wr_way),
    .wr_index_i    (wr_index),
    .wr_tag_i      (tag_wr),
    .lru_we_i      (lru_we),
    .lru_index_i   (lru_index),
    .lru_way_i     (lru_way),
    .clear_all_i   (clear_all),
    .tag_o         (tag_rd),
    .valid_o       (valid_rd),
    .lru_o         (lru_rd)
  );

  icache_data_store #(
    .sets_p        (sets_p),
    .block_words_p (block_words_p)
  ) data_store_i (
    .clk_i,
    .rd_en_i       (rd_en),
    .rd_index_i    (rd_index),
    .wr_en_i       (wr_en),
    .wr_way_i      (wr_way),
    .wr_index_i    (wr_index),
    .wr_word_i     (wr_word),
    .wr_data_i     (wr_data),
    .line_o        (line_rd)
  );

  icache_refill #(
    .sets_p        (sets_p),
    .block_words_p (block_words_p)
  ) refill_i (
    .clk_i, .reset_i,
    .refill_v_i    (refill_v),
    .refill_addr_i (refill_addr),
    .victim_way_i  (victim_way),
    .busy_o        (refill_busy),
    .wb_o, .wb_dat_i, .wb_ack_i,
    .wr_en_o       (wr_en),
    .wr_way_o      (wr_way),
    .wr_index_o    (wr_index),
    .wr_word_o     (wr_word),
    .wr_data_o     (wr_data),
    .tag_we_o      (tag_we),
    .tag_o         (tag_wr)
  );

endmodule

`default_nettype wire

// File: hdl/icache_refill.sv
//////////////////////////////////////////////////
// Refill engine
// Miss FSM and Wishbone classic master that reads
// a whole line word by word, then installs the tag
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module icache_refill #(
  parameter int sets_p        = 16,
  parameter int block_words_p = 4,
  localparam int offset_w = $clog2(block_words_p),
  localparam int index_w  = $clog2(sets_p),
  localparam int tag_w    = icache_pkg::addr_width - 2 - offset_w - index_w
) (
  input  wire                                  clk_i,
  input  wire                                  reset_i,
  input  wire                                  refill_v_i,
  input  wire [icache_pkg::addr_width-1:0]     refill_addr_i,
  input  wire                                  victim_way_i,
  output logic                                 busy_o,
  // Wishbone classic master
  output icache_pkg::wb_m2s_s                  wb_o,
  input  wire [icache_pkg::word_width-1:0]     wb_dat_i,
  input  wire                                  wb_ack_i,
  // Data store write port
  output logic                                 wr_en_o,
  output logic                                 wr_way_o,
  output logic [index_w-1:0]                   wr_index_o,
  output logic [offset_w-1:0]                  wr_word_o,
  output logic [icache_pkg::word_width-1:0]    wr_data_o,
  // Tag install
  output logic                                 tag_we_o,
  output logic [tag_w-1:0]                     tag_o
);

  localparam int idx_lsb = 2 + offset_w;
  localparam int tag_lsb = idx_lsb + index_w;

  icache_pkg::refill_state_e         state_r;
  logic                              stb_r;
  logic [icache_pkg::addr_width-1:0] addr_r;
  logic                              way_r;
  logic [offset_w-1:0]               word_r;
  logic                              ack;
  logic                              last_word;

  assign ack       = stb_r & wb_ack_i;
  assign last_word = (word_r == offset_w'(block_words_p - 1));

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= icache_pkg::e_idle;
      stb_r   <= 1'b0;
    end
    else
    begin
      case (state_r)
        icache_pkg::e_idle:
        begin
          if (refill_v_i)
          begin
            state_r <= icache_pkg::e_read;
            stb_r   <= 1'b1;
          end
        end
        icache_pkg::e_read:
        begin
          // stb low for one cycle between words
          if (ack)
          begin
            stb_r <= 1'b0;
            if (last_word)
              state_r <= icache_pkg::e_install;
          end
          else
            stb_r <= 1'b1;
        end
        icache_pkg::e_install:
          state_r <= icache_pkg::e_idle;
        default:
          state_r <= icache_pkg::e_idle;
      endcase
    end
  end

  // Miss address and victim held for the whole fill
  always_ff @(posedge clk_i)
  begin
    if (state_r == icache_pkg::e_idle && refill_v_i)
    begin
      addr_r <= refill_addr_i;
      way_r  <= victim_way_i;
      word_r <= '0;
    end
    else if (ack)
      word_r <= word_r + 1'b1;
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////
  assign busy_o = (state_r != icache_pkg::e_idle);

  // Line-aligned base, ascending word order
  assign wb_o = '{cyc: (state_r == icache_pkg::e_read),
                  stb: stb_r,
                  adr: {addr_r[icache_pkg::addr_width-1:idx_lsb], word_r, 2'b00}};

  assign wr_en_o    = ack;
  assign wr_way_o   = way_r;
  assign wr_index_o = addr_r[idx_lsb +: index_w];
  assign wr_word_o  = word_r;
  assign wr_data_o  = wb_dat_i;

  assign tag_we_o = (state_r == icache_pkg::e_install);
  assign tag_o    = addr_r[tag_lsb +: tag_w];

endmodule

`default_nettype wire

// File: hdl/icache_lookup.sv
//////////////////////////////////////////////////
// Lookup pipeline
// Decode, tag lookup and tag verify stages with
// hit detection, victim choice and word select
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module icache_lookup #(
  parameter int sets_p        = 16,
  parameter int block_words_p = 4,
  localparam int offset_w = $clog2(block_words_p),
  localparam int index_w  = $clog2(sets_p),
  localparam int tag_w    = icache_pkg::addr_width - 2 - offset_w - index_w
) (
  input  wire                                  clk_i,
  input  wire                                  reset_i,
  input  wire                                  fetch_v_i,
  input  wire icache_pkg::icache_op_e          fetch_op_i,
  input  wire [icache_pkg::addr_width-1:0]     fetch_addr_i,
  output logic                                 ready_o,
  output logic                                 rd_en_o,
  output logic [index_w-1:0]                   rd_index_o,
  input  wire [icache_pkg::ways-1:0][tag_w-1:0] tag_i,
  input  wire [icache_pkg::ways-1:0]           valid_i,
  input  wire                                  lru_i,
  input  wire [icache_pkg::ways-1:0][block_words_p-1:0][icache_pkg::word_width-1:0] line_i,
  output logic [icache_pkg::word_width-1:0]    data_o,
  output logic                                 data_v_o,
  output logic                                 miss_v_o,
  output logic                                 refill_v_o,
  output logic [icache_pkg::addr_width-1:0]    refill_addr_o,
  output logic                                 victim_way_o,
  input  wire                                  refill_busy_i,
  output logic                                 lru_we_o,
  output logic [index_w-1:0]                   lru_index_o,
  output logic                                 lru_way_o,
  output logic                                 clear_all_o
);

  localparam int idx_lsb = 2 + offset_w;
  localparam int tag_lsb = idx_lsb + index_w;

  logic                                                 run_r;
  logic                                                 dec_v_r;
  icache_pkg::fetch_req_s                               dec_req_r;
  logic                                                 tl_v_r;
  icache_pkg::fetch_req_s                               tl_req_r;
  logic                                                 tv_v_r;
  icache_pkg::fetch_req_s                               tv_req_r;
  logic [icache_pkg::ways-1:0]                          tv_hit_r;
  logic [block_words_p-1:0][icache_pkg::word_width-1:0] tv_line_r;
  logic                                                 tv_victim_r;

  logic                        accept;
  logic [icache_pkg::ways-1:0] tl_hit;
  logic                        tl_mru;
  logic                        tl_victim;
  logic                        tv_fetch;
  logic                        tv_fence;
  logic                        tv_stop;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////
  assign accept     = fetch_v_i & ready_o;
  assign rd_en_o    = dec_v_r;
  assign rd_index_o = dec_req_r.addr[idx_lsb +: index_w];

  // Blocked while a miss or fence drains or a refill runs
  assign ready_o = run_r & ~tv_stop & ~refill_busy_i;

  // Requests in decode die too when a miss or fence sits in tag verify
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      run_r   <= 1'b0;
      dec_v_r <= 1'b0;
      tl_v_r  <= 1'b0;
    end
    else
    begin
      run_r   <= 1'b1;
      dec_v_r <= accept;
      tl_v_r  <= dec_v_r & ~tv_stop;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      dec_req_r <= '{op: fetch_op_i, addr: fetch_addr_i};
    if (dec_v_r)
      tl_req_r <= dec_req_r;
  end

  //////////////////////////////////////////////////
  // Tag lookup
  //////////////////////////////////////////////////
  for (genvar w = 0; w < icache_pkg::ways; w++)
  begin : g_cmp
    assign tl_hit[w] = valid_i[w] & (tag_i[w] == tl_req_r.addr[tag_lsb +: tag_w]);
  end

  // Hit in tag verify on the same set makes the stored LRU bit stale
  assign tl_mru = (lru_we_o && lru_index_o == tl_req_r.addr[idx_lsb +: index_w])
                  ? lru_way_o : lru_i;

  always_comb
  begin
    if (!valid_i[0])
      tl_victim = 1'b0;
    else if (!valid_i[1])
      tl_victim = 1'b1;
    else
      tl_victim = ~tl_mru;
  end

  // Younger request dies when a miss or fence sits in tag verify
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tv_v_r <= 1'b0;
    else
      tv_v_r <= tl_v_r & ~tv_stop;
  end

  always_ff @(posedge clk_i)
  begin
    if (tl_v_r)
    begin
      tv_req_r    <= tl_req_r;
      tv_hit_r    <= tl_hit;
      tv_line_r   <= tl_hit[1] ? line_i[1] : line_i[0];
      tv_victim_r <= tl_victim;
    end
  end

  //////////////////////////////////////////////////
  // Tag verify
  //////////////////////////////////////////////////
  assign tv_fetch = tv_v_r & (tv_req_r.op == icache_pkg::e_op_fetch);
  assign tv_fence = tv_v_r & (tv_req_r.op == icache_pkg::e_op_fence);
  assign tv_stop  = miss_v_o | tv_fence;

  assign data_o   = tv_line_r[tv_req_r.addr[2 +: offset_w]];
  assign data_v_o = tv_fetch & (|tv_hit_r);
  assign miss_v_o = tv_fetch & ~(|tv_hit_r);

  assign refill_v_o    = miss_v_o;
  assign refill_addr_o = tv_req_r.addr;
  assign victim_way_o  = tv_victim_r;

  assign lru_we_o    = data_v_o;
  assign lru_index_o = tv_req_r.addr[idx_lsb +: index_w];
  assign lru_way_o   = tv_hit_r[1];
  assign clear_all_o = tv_fence;

endmodule

`default_nettype wire

// File: hdl/icache_data_store.sv
//////////////////////////////////////////////////
// Data store
// One line RAM per way, read a whole line at a
// time and written a word at a time on refill
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module icache_data_store #(
  parameter int sets_p        = 16,
  parameter int block_words_p = 4,
  localparam int offset_w = $clog2(block_words_p),
  localparam int index_w  = $clog2(sets_p)
) (
  input  wire                                  clk_i,
  input  wire                                  rd_en_i,
  input  wire [index_w-1:0]                    rd_index_i,
  input  wire                                  wr_en_i,
  input  wire                                  wr_way_i,
  input  wire [index_w-1:0]                    wr_index_i,
  input  wire [offset_w-1:0]                   wr_word_i,
  input  wire [icache_pkg::word_width-1:0]     wr_data_i,
  output logic [icache_pkg::ways-1:0][block_words_p-1:0][icache_pkg::word_width-1:0] line_o
);

  for (genvar w = 0; w < icache_pkg::ways; w++)
  begin : g_way
    logic [block_words_p-1:0][icache_pkg::word_width-1:0] mem [sets_p];
    logic [block_words_p-1:0][icache_pkg::word_width-1:0] rd_r;

    // Word write during refill
    always_ff @(posedge clk_i)
    begin
      if (wr_en_i && wr_way_i == 1'(w))
        mem[wr_index_i][wr_word_i] <= wr_data_i;
    end

    // Full line read in decode
    always_ff @(posedge clk_i)
    begin
      if (rd_en_i)
        rd_r <= mem[rd_index_i];
    end

    assign line_o[w] = rd_r;
  end

endmodule

`default_nettype wire

// File: hdl/icache_tag_store.sv
//////////////////////////////////////////////////
// Tag store
// One synchronous tag RAM per way, plus valid and
// LRU flops read in step with the RAM
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module icache_tag_store #(
  parameter int sets_p        = 16,
  parameter int block_words_p = 4,
  localparam int index_w = $clog2(sets_p),
  localparam int tag_w   = icache_pkg::addr_width - 2 - $clog2(block_words_p) - index_w
) (
  input  wire                                  clk_i,
  input  wire                                  reset_i,
  input  wire                                  rd_en_i,
  input  wire [index_w-1:0]                    rd_index_i,
  input  wire                                  wr_en_i,
  input  wire                                  wr_way_i,
  input  wire [index_w-1:0]                    wr_index_i,
  input  wire [tag_w-1:0]                      wr_tag_i,
  input  wire                                  lru_we_i,
  input  wire [index_w-1:0]                    lru_index_i,
  input  wire                                  lru_way_i,
  input  wire                                  clear_all_i,
  output logic [icache_pkg::ways-1:0][tag_w-1:0] tag_o,
  output logic [icache_pkg::ways-1:0]          valid_o,
  output logic                                 lru_o
);

  // Per set, one valid bit per way
  logic [sets_p-1:0][icache_pkg::ways-1:0] valid_r;
  // Per set, the most recently used way
  logic [sets_p-1:0]                       lru_r;

  for (genvar w = 0; w < icache_pkg::ways; w++)
  begin : g_way
    logic [tag_w-1:0] mem [sets_p];
    logic [tag_w-1:0] rd_r;

    always_ff @(posedge clk_i)
    begin
      if (wr_en_i && wr_way_i == 1'(w))
        mem[wr_index_i] <= wr_tag_i;
      if (rd_en_i)
        rd_r <= mem[rd_index_i];
    end

    assign tag_o[w] = rd_r;
  end

  // Fence clears every line at once
  always_ff @(posedge clk_i)
  begin
    if (reset_i || clear_all_i)
      valid_r <= '0;
    else if (wr_en_i)
      valid_r[wr_index_i][wr_way_i] <= 1'b1;
  end

  // A freshly installed way counts as most recently used
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      lru_r <= '0;
    else if (wr_en_i)
      lru_r[wr_index_i] <= wr_way_i;
    else if (lru_we_i)
      lru_r[lru_index_i] <= lru_way_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_en_i)
    begin
      valid_o <= valid_r[rd_index_i];
      // Pick up a hit update to the same set in this cycle
      if (lru_we_i && lru_index_i == rd_index_i)
        lru_o <= lru_way_i;
      else
        lru_o <= lru_r[rd_index_i];
    end
  end

endmodule

`default_nettype wire

// File: hdl/icache_pkg.sv
//////////////////////////////////////////////////
// Instruction cache shared definitions
// Address and word widths, request opcodes, the
// refill FSM states and the Wishbone master struct
//////////////////////////////////////////////////
`default_nettype none

package icache_pkg;

  localparam int addr_width = 32;
  localparam int word_width = 32;

  // Two ways, so one LRU bit per set is enough
  localparam int ways = 2;

  typedef enum logic {
    e_op_fetch = 1'b0,
    e_op_fence = 1'b1
  } icache_op_e;

  // Request as held in the tag lookup and tag verify stages
  typedef struct packed {
    icache_op_e            op;
    logic [addr_width-1:0] addr;
  } fetch_req_s;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic [addr_width-1:0] adr;
  } wb_m2s_s;

  typedef enum logic [1:0] {
    e_idle    = 2'd0,
    e_read    = 2'd1,
    e_install = 2'd2
  } refill_state_e;

endpackage

`default_nettype wire
